// File: hw/soc_settings.svh
//------------------------------------------------------------
// System bus core settings
// Bus widths, address map, CSR banks and reset timing
//------------------------------------------------------------
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Wishbone data bus
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// CSR address, 4-bit bank above a 10-bit register
`define SOC_CSR_A_W 14

// Scratch RAM depth in words
`define SOC_RAM_WORDS 256

// Reload of the reset debounce counter
`define SOC_RST_DEBOUNCE 255

// Region codes on address bits 30:28
`define SOC_REGION_RAM 3'b000
`define SOC_REGION_CSR 3'b110

// CSR banks
`define SOC_BANK_SYSCTL 4'h1
`define SOC_BANK_TIMER 4'h2

// Release 1.2.0 final on M1
`define SOC_SYSTEM_ID 32'h12004D31

// Top address bits that must be clear for a null pointer
`define SOC_NULL_LIMIT_W 14

`endif

// File: hw/soc_pkg.sv
//------------------------------------------------------------
// Shared types of the system bus core
// Bus words, CSR address and FSM encodings
//------------------------------------------------------------
`include "soc_settings.svh"

package soc_pkg;

	// Wishbone words
	typedef logic [`SOC_ADDR_W-1:0] wb_addr_t;
	typedef logic [`SOC_DATA_W-1:0] wb_data_t;
	typedef logic [`SOC_SEL_W-1:0] wb_sel_t;

	// Bank in the top 4 bits, register below
	typedef logic [`SOC_CSR_A_W-1:0] csr_addr_t;

	// Region code, same width as the map constants
	typedef logic [$bits(`SOC_REGION_RAM)-1:0] region_t;

	// One bus cycle at a time
	typedef enum logic [1:0] {
		bus_idle,
		bus_busy,
		bus_resp
	} bus_state_t;

	// Decoded target of a cycle
	typedef enum logic [1:0] {
		slave_ram,
		slave_csr,
		slave_none
	} slave_sel_t;

endpackage

// File: hw/reset_gen.sv
//------------------------------------------------------------
// Reset generator
// Debounces the reset request into the internal reset
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_rst_i,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(`SOC_RST_DEBOUNCE + 1);

	// Power-up values hold the core in reset
	logic             req_q = 1'b1;
	logic [CNT_W-1:0] rst_cnt = CNT_W'(`SOC_RST_DEBOUNCE);
	logic             rst_q = 1'b1;

	always_ff @(posedge sys_clk) begin
		// Button or software hard reset
		req_q <= trigger_reset | hard_rst_i;
		// Reload while requested, else drain to zero
		if (req_q) begin
			rst_cnt <= CNT_W'(`SOC_RST_DEBOUNCE);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
		rst_q <= rst_cnt != '0;
	end

	assign sys_rst_o = rst_q;

endmodule

// File: hw/bus_ctrl.sv
//------------------------------------------------------------
// System bus switch
// Decodes the region, runs one slave cycle at a time and
// answers the master with ack, or err for unmapped regions
// and null pointers
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_ctrl (
	input  logic              sys_clk,
	input  logic              sys_rst_i,
	// Master port
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic              wb_we_i,
	input  soc_pkg::wb_addr_t wb_adr_i,
	input  soc_pkg::wb_sel_t  wb_sel_i,
	input  soc_pkg::wb_data_t wb_dat_i,
	output soc_pkg::wb_data_t wb_dat_o,
	output logic              wb_ack_o,
	output logic              wb_err_o,
	input  logic              bus_err_en_i,
	// Scratch RAM
	output logic              ram_cyc_o,
	output logic              ram_stb_o,
	output logic              ram_we_o,
	output soc_pkg::wb_addr_t ram_adr_o,
	output soc_pkg::wb_sel_t  ram_sel_o,
	output soc_pkg::wb_data_t ram_dat_o,
	input  soc_pkg::wb_data_t ram_dat_i,
	input  logic              ram_ack_i,
	// CSR bridge
	output logic              csr_cyc_o,
	output logic              csr_stb_o,
	output logic              csr_we_o,
	output soc_pkg::wb_addr_t csr_adr_o,
	output soc_pkg::wb_sel_t  csr_sel_o,
	output soc_pkg::wb_data_t csr_dat_o,
	input  soc_pkg::wb_data_t csr_dat_i,
	input  logic              csr_ack_i
);

	soc_pkg::bus_state_t state;
	soc_pkg::slave_sel_t target;
	soc_pkg::slave_sel_t decoded;
	soc_pkg::region_t    region;
	logic                null_hit;
	logic                null_q;
	logic                slave_ack;

	// Bit 31 not decoded, every region has a shadow copy
	assign region = wb_adr_i[`SOC_ADDR_W-2 -: $bits(soc_pkg::region_t)];

	always_comb begin
		case (region)
			`SOC_REGION_RAM: decoded = soc_pkg::slave_ram;
			`SOC_REGION_CSR: decoded = soc_pkg::slave_csr;
			default:         decoded = soc_pkg::slave_none;
		endcase
	end

	// Null pointer, all top bits clear while checking is on
	assign null_hit = bus_err_en_i &
		(wb_adr_i[`SOC_ADDR_W-1 -: `SOC_NULL_LIMIT_W] == '0);

	// Master holds its lines, so only the strobes are switched
	assign ram_cyc_o = (state == soc_pkg::bus_busy) && (target == soc_pkg::slave_ram);
	assign ram_stb_o = ram_cyc_o;
	assign ram_we_o  = wb_we_i;
	assign ram_adr_o = wb_adr_i;
	assign ram_sel_o = wb_sel_i;
	assign ram_dat_o = wb_dat_i;

	assign csr_cyc_o = (state == soc_pkg::bus_busy) && (target == soc_pkg::slave_csr);
	assign csr_stb_o = csr_cyc_o;
	assign csr_we_o  = wb_we_i;
	assign csr_adr_o = wb_adr_i;
	assign csr_sel_o = wb_sel_i;
	assign csr_dat_o = wb_dat_i;

	assign slave_ack = (ram_cyc_o & ram_ack_i) | (csr_cyc_o & csr_ack_i);

	//------------------------------------------------------------
	// Cycle FSM
	//------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= soc_pkg::bus_idle;
			target   <= soc_pkg::slave_none;
			null_q   <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			// Responses are single-cycle pulses
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
			case (state)
				soc_pkg::bus_idle: begin
					if (wb_cyc_i && wb_stb_i) begin
						target <= decoded;
						null_q <= null_hit;
						state  <= soc_pkg::bus_busy;
					end
				end
				soc_pkg::bus_busy: begin
					// Unmapped, no slave to wait for
					if (target == soc_pkg::slave_none) begin
						wb_err_o <= 1'b1;
						state    <= soc_pkg::bus_resp;
					end else if (slave_ack) begin
						wb_ack_o <= ~null_q;
						wb_err_o <= null_q;
						state    <= soc_pkg::bus_resp;
					end
				end
				// Master drops stb after its response
				default: state <= soc_pkg::bus_idle;
			endcase
		end
	end

	// Read data follows the active slave, zero when unmapped
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::bus_busy) begin
			case (target)
				soc_pkg::slave_ram: wb_dat_o <= ram_dat_i;
				soc_pkg::slave_csr: wb_dat_o <= csr_dat_i;
				default:            wb_dat_o <= '0;
			endcase
		end
	end

endmodule

// File: hw/scratch_ram.sv
//------------------------------------------------------------
// Scratch RAM
// Word memory slave with byte lane writes
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module scratch_ram (
	input  logic              sys_clk,
	input  logic              ram_cyc_i,
	input  logic              ram_stb_i,
	input  logic              ram_we_i,
	input  soc_pkg::wb_addr_t ram_adr_i,
	input  soc_pkg::wb_sel_t  ram_sel_i,
	input  soc_pkg::wb_data_t ram_dat_i,
	output soc_pkg::wb_data_t ram_dat_o,
	output logic              ram_ack_o
);

	localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

	soc_pkg::wb_data_t mem [`SOC_RAM_WORDS];
	logic [IDX_W-1:0]  idx;
	logic              req;

	// Word index, higher address bits alias
	assign idx = ram_adr_i[IDX_W+1:2];
	// New access only once the last ack is gone
	assign req = ram_cyc_i & ram_stb_i & ~ram_ack_o;

	always_ff @(posedge sys_clk) begin
		ram_ack_o <= req;
		if (req) begin
			// Whole word read, old data on a write
			ram_dat_o <= mem[idx];
			if (ram_we_i) begin
				for (int b = 0; b < $bits(soc_pkg::wb_sel_t); b++) begin
					if (ram_sel_i[b])
						mem[idx][8*b +: 8] <= ram_dat_i[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: hw/csr_bridge.sv
//------------------------------------------------------------
// Wishbone to CSR bridge
// Issues one word access on the CSR bus and returns the
// OR of all bank read data
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module csr_bridge (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	input  logic               wb_we_i,
	input  soc_pkg::wb_addr_t  wb_adr_i,
	input  soc_pkg::wb_data_t  wb_dat_i,
	output soc_pkg::wb_data_t  wb_dat_o,
	output logic               wb_ack_o,
	// CSR bus
	output soc_pkg::csr_addr_t csr_a_o,
	output logic               csr_we_o,
	output soc_pkg::wb_data_t  csr_dw_o,
	input  soc_pkg::wb_data_t  csr_dr_sys_i,
	input  soc_pkg::wb_data_t  csr_dr_tmr_i
);

	// idle issues, busy captures, resp acks
	soc_pkg::bus_state_t state;

	// Word address, byte selects play no part
	assign csr_a_o  = wb_adr_i[`SOC_CSR_A_W+1:2];
	assign csr_dw_o = wb_dat_i;
	// Write strobe lives in the issue cycle only
	assign csr_we_o = (state == soc_pkg::bus_idle) & wb_cyc_i & wb_stb_i & wb_we_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= soc_pkg::bus_idle;
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			case (state)
				soc_pkg::bus_idle: begin
					if (wb_cyc_i && wb_stb_i)
						state <= soc_pkg::bus_busy;
				end
				// Banks have answered by now
				soc_pkg::bus_busy: begin
					wb_ack_o <= 1'b1;
					state    <= soc_pkg::bus_resp;
				end
				// Switch sees ack, stb falls
				default: state <= soc_pkg::bus_idle;
			endcase
		end
	end

	// Idle banks drive zero, so OR selects
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::bus_busy)
			wb_dat_o <= csr_dr_sys_i | csr_dr_tmr_i;
	end

endmodule

// File: hw/sysctl_regs.sv
//------------------------------------------------------------
// System controller CSR bank
// GPIO with interrupt, LEDs, system ID, bus-error enable
// and the software hard reset
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module sysctl_regs (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  soc_pkg::csr_addr_t csr_a_i,
	input  logic               csr_we_i,
	input  soc_pkg::wb_data_t  csr_dw_i,
	output soc_pkg::wb_data_t  csr_dr_o,
	input  logic [2:0]         gpio_i,
	output logic [1:0]         leds_o,
	output logic               gpio_irq_o,
	output logic               bus_err_en_o,
	output logic               hard_rst_o
);

	localparam int REG_W = `SOC_CSR_A_W - 4;

	logic [2:0]       gpio_meta;
	logic [2:0]       gpio_sync;
	logic [2:0]       irq_en;
	logic             bank_hit;
	logic [REG_W-1:0] reg_sel;

	assign bank_hit = csr_a_i[`SOC_CSR_A_W-1 -: 4] == `SOC_BANK_SYSCTL;
	assign reg_sel  = csr_a_i[REG_W-1:0];

	// Two-flop synchronizer for the buttons
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_dr_o     <= '0;
			leds_o       <= '0;
			irq_en       <= '0;
			bus_err_en_o <= 1'b0;
			hard_rst_o   <= 1'b0;
		end else begin
			csr_dr_o   <= '0;
			hard_rst_o <= 1'b0;
			if (bank_hit) begin
				if (csr_we_i) begin
					case (reg_sel)
						REG_W'(1): leds_o <= csr_dw_i[1:0];
						REG_W'(2): irq_en <= csr_dw_i[2:0];
						REG_W'(4): begin
							bus_err_en_o <= csr_dw_i[0];
							// One-cycle pulse restarts the reset counter
							hard_rst_o   <= csr_dw_i[1];
						end
						default: ;
					endcase
				end
				case (reg_sel)
					REG_W'(0): csr_dr_o <= soc_pkg::wb_data_t'(gpio_sync);
					REG_W'(1): csr_dr_o <= soc_pkg::wb_data_t'(leds_o);
					REG_W'(2): csr_dr_o <= soc_pkg::wb_data_t'(irq_en);
					REG_W'(3): csr_dr_o <= `SOC_SYSTEM_ID;
					REG_W'(4): csr_dr_o <= soc_pkg::wb_data_t'(bus_err_en_o);
					default:   csr_dr_o <= '0;
				endcase
			end
		end
	end

	// Level interrupt, any enabled input high
	assign gpio_irq_o = |(gpio_sync & irq_en);

endmodule

// File: hw/csr_timer.sv
//------------------------------------------------------------
// Timer CSR bank
// Compare timer with autoreload and a sticky interrupt
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module csr_timer (
	input  logic               sys_clk,
	input  logic               sys_rst_i,
	input  soc_pkg::csr_addr_t csr_a_i,
	input  logic               csr_we_i,
	input  soc_pkg::wb_data_t  csr_dw_i,
	output soc_pkg::wb_data_t  csr_dr_o,
	output logic               timer_irq_o
);

	localparam int REG_W = `SOC_CSR_A_W - 4;

	logic              bank_hit;
	logic [REG_W-1:0]  reg_sel;
	logic              en_q;
	logic              reload_q;
	soc_pkg::wb_data_t compare_q;
	soc_pkg::wb_data_t counter_q;

	assign bank_hit = csr_a_i[`SOC_CSR_A_W-1 -: 4] == `SOC_BANK_TIMER;
	assign reg_sel  = csr_a_i[REG_W-1:0];

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_dr_o    <= '0;
			en_q        <= 1'b0;
			reload_q    <= 1'b0;
			compare_q   <= '0;
			counter_q   <= '0;
			timer_irq_o <= 1'b0;
		end else begin
			// Count up to compare
			if (en_q) begin
				if (counter_q == compare_q) begin
					timer_irq_o <= 1'b1;
					if (reload_q)
						counter_q <= '0;
					else
						en_q <= 1'b0;
				end else begin
					counter_q <= counter_q + 1'b1;
				end
			end
			csr_dr_o <= '0;
			if (bank_hit) begin
				// Writes win over the count logic
				if (csr_we_i) begin
					case (reg_sel)
						REG_W'(0): begin
							en_q        <= csr_dw_i[0];
							reload_q    <= csr_dw_i[1];
							timer_irq_o <= 1'b0;
						end
						REG_W'(1): compare_q <= csr_dw_i;
						REG_W'(2): counter_q <= csr_dw_i;
						default: ;
					endcase
				end
				case (reg_sel)
					REG_W'(0): csr_dr_o <= soc_pkg::wb_data_t'({reload_q, en_q});
					REG_W'(1): csr_dr_o <= compare_q;
					REG_W'(2): csr_dr_o <= counter_q;
					default:   csr_dr_o <= '0;
				endcase
			end
		end
	end

endmodule

// File: hw/soc_top.sv
//------------------------------------------------------------
// System bus core top level
// Bus switch, scratch RAM, CSR bridge, system controller,
// timer and reset generator
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
	input  logic                   sys_clk,
	input  logic                   trigger_reset,
	// Wishbone data bus, CPU side
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`SOC_ADDR_W-1:0] wb_adr_i,
	input  logic [`SOC_SEL_W-1:0]  wb_sel_i,
	input  logic [`SOC_DATA_W-1:0] wb_dat_i,
	output logic [`SOC_DATA_W-1:0] wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   wb_err_o,
	// Board I/O
	input  logic [2:0]             gpio_i,
	output logic [1:0]             leds_o,
	// Interrupt vector, bit 0 GPIO and bit 1 timer
	output logic [1:0]             irq_o
);

	logic sys_rst;
	logic hard_rst;
	logic bus_err_en;

	// RAM slave
	logic                   ram_cyc;
	logic                   ram_stb;
	logic                   ram_we;
	logic                   ram_ack;
	logic [`SOC_ADDR_W-1:0] ram_adr;
	logic [`SOC_SEL_W-1:0]  ram_sel;
	logic [`SOC_DATA_W-1:0] ram_dat_w;
	logic [`SOC_DATA_W-1:0] ram_dat_r;

	// CSR bridge slave
	logic                   brg_cyc;
	logic                   brg_stb;
	logic                   brg_we;
	logic                   brg_ack;
	logic [`SOC_ADDR_W-1:0] brg_adr;
	logic [`SOC_DATA_W-1:0] brg_dat_w;
	logic [`SOC_DATA_W-1:0] brg_dat_r;

	// CSR bus
	logic [`SOC_CSR_A_W-1:0] csr_a;
	logic                    csr_we;
	logic [`SOC_DATA_W-1:0]  csr_dw;
	logic [`SOC_DATA_W-1:0]  csr_dr_sys;
	logic [`SOC_DATA_W-1:0]  csr_dr_tmr;

	//------------------------------------------------------------
	// Reset and bus switch
	//------------------------------------------------------------
	reset_gen rst0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_rst_i    (hard_rst),
		.sys_rst_o     (sys_rst)
	);

	bus_ctrl bus0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_sel_i     (wb_sel_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.wb_err_o     (wb_err_o),
		.bus_err_en_i (bus_err_en),
		.ram_cyc_o    (ram_cyc),
		.ram_stb_o    (ram_stb),
		.ram_we_o     (ram_we),
		.ram_adr_o    (ram_adr),
		.ram_sel_o    (ram_sel),
		.ram_dat_o    (ram_dat_w),
		.ram_dat_i    (ram_dat_r),
		.ram_ack_i    (ram_ack),
		.csr_cyc_o    (brg_cyc),
		.csr_stb_o    (brg_stb),
		.csr_we_o     (brg_we),
		.csr_adr_o    (brg_adr),
		.csr_sel_o    (),
		.csr_dat_o    (brg_dat_w),
		.csr_dat_i    (brg_dat_r),
		.csr_ack_i    (brg_ack)
	);

	//------------------------------------------------------------
	// Slaves
	//------------------------------------------------------------
	scratch_ram ram0 (
		.sys_clk   (sys_clk),
		.ram_cyc_i (ram_cyc),
		.ram_stb_i (ram_stb),
		.ram_we_i  (ram_we),
		.ram_adr_i (ram_adr),
		.ram_sel_i (ram_sel),
		.ram_dat_i (ram_dat_w),
		.ram_dat_o (ram_dat_r),
		.ram_ack_o (ram_ack)
	);

	csr_bridge brg0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.wb_cyc_i     (brg_cyc),
		.wb_stb_i     (brg_stb),
		.wb_we_i      (brg_we),
		.wb_adr_i     (brg_adr),
		.wb_dat_i     (brg_dat_w),
		.wb_dat_o     (brg_dat_r),
		.wb_ack_o     (brg_ack),
		.csr_a_o      (csr_a),
		.csr_we_o     (csr_we),
		.csr_dw_o     (csr_dw),
		.csr_dr_sys_i (csr_dr_sys),
		.csr_dr_tmr_i (csr_dr_tmr)
	);

	// CSR banks share the bus, each decodes its own bank
	sysctl_regs sysctl0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr_sys),
		.gpio_i       (gpio_i),
		.leds_o       (leds_o),
		.gpio_irq_o   (irq_o[0]),
		.bus_err_en_o (bus_err_en),
		.hard_rst_o   (hard_rst)
	);

	csr_timer timer0 (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.csr_a_i     (csr_a),
		.csr_we_i    (csr_we),
		.csr_dw_i    (csr_dw),
		.csr_dr_o    (csr_dr_tmr),
		.timer_irq_o (irq_o[1])
	);

endmodule

// File: test/tb_clock.sv
//------------------------------------------------------------
// Testbench clock and reset
// 20 ns clock, reset request held for 8 cycles
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock (
	output logic sys_clk,
	output logic trigger_reset
);

	localparam int half_period = 10;
	localparam int reset_cycles = 8;

	logic clk_q = 1'b0;
	logic rst_q = 1'b1;

	always #(half_period) clk_q = ~clk_q;

	// Release a little after the edge, like the other inputs
	initial begin
		repeat (reset_cycles) @(posedge clk_q);
		#2;
		rst_q = 1'b0;
	end

	assign sys_clk       = clk_q;
	assign trigger_reset = rst_q;

endmodule

// File: test/tb_tasks.svh
//------------------------------------------------------------
// Testbench helpers
// Random source, bus cycles on the data bus, checks and
// per-test reporting
//------------------------------------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
function automatic logic [31:0] lfsr_take(input int nbits);
	logic [31:0] val;
	logic        fb;
	val = '0;
	for (int i = 0; i < nbits; i++) begin
		fb     = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];
		val    = {val[30:0], lfsr_q[0]};
		lfsr_q = {fb, lfsr_q[15:1]};
	end
	return val;
endfunction

// Expected word after a write with byte selects
function automatic soc_pkg::wb_data_t merge_bytes(input soc_pkg::wb_data_t old_w,
		input soc_pkg::wb_data_t new_w, input soc_pkg::wb_sel_t sel);
	soc_pkg::wb_data_t res;
	res = old_w;
	for (int b = 0; b < `SOC_SEL_W; b++) begin
		if (sel[b])
			res[8*b +: 8] = new_w[8*b +: 8];
	end
	return res;
endfunction

// Entered and left 2 ns after a rising edge
task automatic wait_cycles(input int n);
	repeat (n) @(posedge sys_clk);
	#2;
endtask

//------------------------------------------------------------
// One Wishbone classic cycle
//------------------------------------------------------------
task automatic bus_cycle(input logic we, input soc_pkg::wb_addr_t adr,
		input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t wdat,
		output soc_pkg::wb_data_t rdat, output logic ack, output logic err);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = adr;
	wb_sel   = sel;
	wb_dat_w = wdat;
	// Sample 1 ns after the edge, outputs are settled
	do begin
		@(posedge sys_clk);
		#1;
	end while (!(wb_ack || wb_err));
	ack  = wb_ack;
	err  = wb_err;
	rdat = wb_dat_r;
	#1;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
	// stb stays low across one edge
	@(posedge sys_clk);
	#2;
endtask

task automatic check_value(input string name, input soc_pkg::wb_data_t got,
		input soc_pkg::wb_data_t exp);
	assert (got === exp) else begin
		errors++;
		$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
	end
endtask

task automatic check_true(input logic cond, input string what);
	assert (cond) else begin
		errors++;
		$display("%s", what);
	end
endtask

task automatic response_is(input soc_pkg::wb_addr_t adr, input logic ack, input logic err,
		input logic want_ack);
	if (want_ack) begin
		assert (ack && !err) else begin
			errors++;
			$display("Access at 0x%08h ended with err where an ack was due", adr);
		end
	end else begin
		assert (err && !ack) else begin
			errors++;
			$display("Access at 0x%08h ended with ack where an err was due", adr);
		end
	end
endtask

task automatic write_expect_ack(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t dat,
		input soc_pkg::wb_sel_t sel);
	soc_pkg::wb_data_t rdat;
	logic              ack;
	logic              err;
	bus_cycle(1'b1, adr, sel, dat, rdat, ack, err);
	response_is(adr, ack, err, 1'b1);
endtask

task automatic read_expect(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t exp);
	soc_pkg::wb_data_t rdat;
	logic              ack;
	logic              err;
	bus_cycle(1'b0, adr, 4'hF, '0, rdat, ack, err);
	response_is(adr, ack, err, 1'b1);
	check_value($sformatf("wb_dat_o at 0x%08h", adr), rdat, exp);
endtask

// Unmapped answers carry zero data, null pointer answers do not
task automatic access_expect_err(input logic we, input soc_pkg::wb_addr_t adr,
		input logic unmapped);
	soc_pkg::wb_data_t rdat;
	logic              ack;
	logic              err;
	bus_cycle(we, adr, 4'hF, 32'h5A5A_5A5A, rdat, ack, err);
	response_is(adr, ack, err, 1'b0);
	if (unmapped && !we)
		check_value($sformatf("wb_dat_o at 0x%08h", adr), rdat, 32'h0);
endtask

task automatic finish_test(input string name, input int errs_start);
	tests_run++;
	if (errors == errs_start) begin
		tests_ok++;
		$display("test %s: ok", name);
	end else begin
		$display("test %s: %0d errors", name, errors - errs_start);
	end
endtask

`endif

// File: test/soc_tb.sv
//------------------------------------------------------------
// System bus core testbench
// Plays the CPU on the data bus and checks the RAM, error
// answers, system controller, timer and hard reset
//------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_tb;

	// Rough sum of test lengths, hard reset wait included
	localparam int test_cycles = 620;
	localparam int cycle_limit = 4 * (`SOC_RST_DEBOUNCE + test_cycles);

	localparam soc_pkg::wb_addr_t ram_base    = 32'h0004_0000;
	localparam soc_pkg::wb_addr_t ram_shadow  = 32'h8004_0000;
	localparam soc_pkg::wb_addr_t sysctl_base = 32'h6000_1000;
	localparam soc_pkg::wb_addr_t timer_base  = 32'h6000_2000;

	logic              sys_clk;
	logic              trigger_reset;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	soc_pkg::wb_addr_t wb_adr;
	soc_pkg::wb_sel_t  wb_sel;
	soc_pkg::wb_data_t wb_dat_w;
	soc_pkg::wb_data_t wb_dat_r;
	logic              wb_ack;
	logic              wb_err;
	logic [2:0]        gpio;
	logic [1:0]        leds;
	logic [1:0]        irq;

	// Checker state
	int                errors = 0;
	int                tests_run = 0;
	int                tests_ok = 0;
	int                cycle_cnt = 0;
	logic              monitor_on = 1'b0;
	logic              resp_prev = 1'b0;
	logic [15:0]       lfsr_q = 16'd65;
	soc_pkg::wb_data_t ram_model [8];

	`include "tb_tasks.svh"

	tb_clock clk0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset)
	);

	soc_top dut0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_we_i       (wb_we),
		.wb_adr_i      (wb_adr),
		.wb_sel_i      (wb_sel),
		.wb_dat_i      (wb_dat_w),
		.wb_dat_o      (wb_dat_r),
		.wb_ack_o      (wb_ack),
		.wb_err_o      (wb_err),
		.gpio_i        (gpio),
		.leds_o        (leds),
		.irq_o         (irq)
	);

	//------------------------------------------------------------
	// Response protocol, sampled mid-cycle
	//------------------------------------------------------------
	always @(negedge sys_clk) begin
		if (monitor_on) begin
			assert (!(wb_ack && wb_err)) else begin
				errors++;
				$display("Ack and err came in the same cycle at %0t", $time);
			end
			assert (!(resp_prev && (wb_ack || wb_err))) else begin
				errors++;
				$display("A bus response lasted longer than one cycle at %0t", $time);
			end
		end
		resp_prev = wb_ack || wb_err;
	end

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout, the run did not end within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		int                errs;
		int                n;
		soc_pkg::wb_data_t word;
		soc_pkg::wb_sel_t  sel;
		logic [1:0]        led_val;
		logic [2:0]        gpio_val;

		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_sel   = '0;
		wb_dat_w = '0;
		gpio     = '0;

		// Debounced reset has to drain first
		@(negedge trigger_reset);
		wait_cycles(`SOC_RST_DEBOUNCE + 4);
		monitor_on = 1'b1;

		errs = errors;
		check_value("leds_o", 32'(leds), 32'h0);
		check_value("irq_o", 32'(irq), 32'h0);
		check_value("wb_ack_o", 32'(wb_ack), 32'h0);
		check_value("wb_err_o", 32'(wb_err), 32'h0);
		finish_test("reset_state", errs);

		//------------------------------------------------------------
		// Scratch RAM
		//------------------------------------------------------------
		errs = errors;
		// Full words first, so every byte is known
		for (int i = 0; i < 8; i++) begin
			word = lfsr_take(32);
			write_expect_ack(ram_base + 32'(4 * i), word, 4'hF);
			ram_model[i] = word;
		end
		for (int i = 0; i < 8; i++) begin
			word = lfsr_take(32);
			sel  = soc_pkg::wb_sel_t'(lfsr_take(`SOC_SEL_W));
			write_expect_ack(ram_base + 32'(4 * i), word, sel);
			ram_model[i] = merge_bytes(ram_model[i], word, sel);
		end
		for (int i = 0; i < 8; i++)
			read_expect(ram_base + 32'(4 * i), ram_model[i]);
		// Bit 31 is not decoded
		read_expect(ram_shadow + 32'd12, ram_model[3]);
		finish_test("ram_access", errs);

		// Unmapped region
		errs = errors;
		access_expect_err(1'b0, 32'h3000_0000, 1'b1);
		access_expect_err(1'b1, 32'h3000_0004, 1'b1);
		access_expect_err(1'b0, 32'hB000_0000, 1'b1);
		finish_test("unmapped", errs);

		//------------------------------------------------------------
		// Null pointer check
		//------------------------------------------------------------
		errs = errors;
		// Low addresses alias the RAM words
		read_expect(32'h0000_0000, ram_model[0]);
		read_expect(32'h0000_0004, ram_model[1]);
		write_expect_ack(sysctl_base + 32'h10, 32'h1, 4'hF);
		read_expect(sysctl_base + 32'h10, 32'h1);
		access_expect_err(1'b0, 32'h0000_0000, 1'b0);
		read_expect(ram_base, ram_model[0]);
		finish_test("null_check", errs);

		//------------------------------------------------------------
		// System controller
		//------------------------------------------------------------
		errs = errors;
		read_expect(sysctl_base + 32'hC, `SOC_SYSTEM_ID);
		led_val = 2'(lfsr_take(2));
		write_expect_ack(sysctl_base + 32'h4, 32'(led_val), 4'hF);
		check_value("leds_o", 32'(leds), 32'(led_val));
		read_expect(sysctl_base + 32'h4, 32'(led_val));
		// Bit 0 high for the interrupt check
		gpio_val = 3'(lfsr_take(3)) | 3'b001;
		gpio     = gpio_val;
		wait_cycles(3);
		read_expect(sysctl_base, 32'(gpio_val));
		check_value("irq_o[0]", 32'(irq[0]), 32'h0);
		write_expect_ack(sysctl_base + 32'h8, 32'h1, 4'hF);
		check_value("irq_o[0]", 32'(irq[0]), 32'h1);
		write_expect_ack(sysctl_base + 32'h8, 32'h0, 4'hF);
		check_value("irq_o[0]", 32'(irq[0]), 32'h0);
		gpio = '0;
		finish_test("sysctl", errs);

		//------------------------------------------------------------
		// Timer
		//------------------------------------------------------------
		errs = errors;
		write_expect_ack(timer_base + 32'h4, 32'd40, 4'hF);
		read_expect(timer_base + 32'h4, 32'd40);
		write_expect_ack(timer_base, 32'h1, 4'hF);
		n = 0;
		while (!irq[1] && n < 60) begin
			@(posedge sys_clk);
			#1;
			n++;
		end
		check_true(irq[1], "Timer interrupt did not rise within 60 cycles");
		// Sticky until control is written
		repeat (10) begin
			@(posedge sys_clk);
			#1;
			check_true(irq[1], "Timer interrupt fell before control was written");
		end
		#1;
		write_expect_ack(timer_base, 32'h0, 4'hF);
		check_value("irq_o[1]", 32'(irq[1]), 32'h0);
		// Bank 3 has no client
		read_expect(32'h6000_3000, 32'h0);
		finish_test("timer", errs);

		//------------------------------------------------------------
		// Software hard reset
		//------------------------------------------------------------
		errs = errors;
		write_expect_ack(sysctl_base + 32'h4, 32'h3, 4'hF);
		check_value("leds_o", 32'(leds), 32'h3);
		// Enabled GPIO interrupt pending across the reset
		gpio = 3'b001;
		write_expect_ack(sysctl_base + 32'h8, 32'h1, 4'hF);
		check_value("irq_o[0]", 32'(irq[0]), 32'h1);
		write_expect_ack(sysctl_base + 32'h10, 32'h2, 4'hF);
		wait_cycles(`SOC_RST_DEBOUNCE + 4);
		check_value("leds_o", 32'(leds), 32'h0);
		check_value("irq_o", 32'(irq), 32'h0);
		// RAM content survives, null check is off again
		read_expect(ram_base, ram_model[0]);
		read_expect(32'h0000_0000, ram_model[0]);
		read_expect(sysctl_base + 32'h10, 32'h0);
		gpio = '0;
		finish_test("hard_reset", errs);

		$display("%0d tests, %0d ok, %0d failed, %0d check errors",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+hw
+incdir+test
hw/soc_pkg.sv
hw/reset_gen.sv
hw/bus_ctrl.sv
hw/scratch_ram.sv
hw/csr_bridge.sv
hw/sysctl_regs.sv
hw/csr_timer.sv
hw/soc_top.sv
test/tb_clock.sv
test/soc_tb.sv

// File: Makefile
# Verilator build and run of the system bus core testbench

TOP = soc_tb
LOG = sim.log

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

obj_dir/V$(TOP): list.f $(wildcard hw/*.sv hw/*.svh test/*.sv test/*.svh)
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
